// File: logic/mmu_settings.svh
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Instruction TLB depth, power of two
`define MMU_ITLB_ENTRIES 4

// Data TLB depth, power of two
`define MMU_DTLB_ENTRIES 4

// Sv32 physical address width
// 22-bit ppn plus 12-bit page offset
`define MMU_PADDR_W 34

// Both depths must stay at or below 1024
// The TLB index comes from the low vpn bits

`endif

// File: logic/sv32_pkg.sv
`default_nettype none

`include "mmu_settings.svh"

package sv32_pkg;

    typedef logic [31:0]             vaddr_t;
    typedef logic [`MMU_PADDR_W-1:0] paddr_t;
    typedef logic [19:0]             vpn_t;   // {vpn1, vpn0}
    typedef logic [21:0]             ppn_t;   // {ppn1, ppn0}

    // Sv32 page-table entry, V sits in bit 0
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;   // Free for software
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // Instruction side only cares about execute
    typedef struct packed {
        logic x;
        logic u;
    } itlb_perm_t;

    // Data side payload
    typedef struct packed {
        logic r;
        logic w;
        logic u;
    } dtlb_perm_t;

endpackage

`default_nettype wire

// File: logic/walk_pkg.sv
`default_nettype none

package walk_pkg;

    // Walker FSM
    typedef enum logic [1:0] {
        IDLE,
        L1_READ,   // Root level, may end in a superpage
        L0_READ,
        REFILL     // One-cycle update strobe
    } walk_state_t;

    // Which TLB started the walk
    typedef enum logic {
        INSTR,
        DATA
    } miss_src_t;

endpackage

`default_nettype wire

// File: logic/tlb.sv
`default_nettype none

module tlb #(
    parameter type         payload_t = logic [1:0],
    parameter int unsigned ENTRIES   = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Lookup from the core
    input  logic                  req,
    input  wire sv32_pkg::vaddr_t vaddr,
    output logic                  hit,
    output logic                  miss,
    output sv32_pkg::paddr_t      paddr,
    output payload_t              payload,

    // Flush and refill
    input  logic                  flush,
    input  logic                  upd,
    input  wire sv32_pkg::vpn_t   upd_vpn,
    input  wire sv32_pkg::ppn_t   upd_ppn,
    input  logic                  upd_super,
    input  wire payload_t         upd_payload
);
    import sv32_pkg::*;

    localparam int unsigned IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] super_q;
    logic [9:0]         vpn1_q    [ENTRIES];
    logic [9:0]         vpn0_q    [ENTRIES];
    ppn_t               ppn_q     [ENTRIES];
    payload_t           payload_q [ENTRIES];

    logic [9:0]         vpn1;
    logic [9:0]         vpn0;
    logic [IDX_W-1:0]   sp_idx;
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wr_idx;
    logic               sp_sel;
    logic               match;
    ppn_t               rd_ppn;

    assign vpn1 = vaddr[31:22];
    assign vpn0 = vaddr[21:12];

    // A valid superpage in the vpn1 slot takes the index
    assign sp_idx = vpn1[IDX_W-1:0];
    assign sp_sel = valid_q[sp_idx] && super_q[sp_idx];
    assign rd_idx = sp_sel ? sp_idx : vpn0[IDX_W-1:0];

    always_comb begin
        match = valid_q[rd_idx] && (vpn1_q[rd_idx] == vpn1);
        if (!super_q[rd_idx] && (vpn0_q[rd_idx] != vpn0)) begin
            match = 1'b0;   // 4 KB page needs vpn0 too
        end
    end

    assign hit  = req && match;
    assign miss = req && !match;

    assign rd_ppn  = ppn_q[rd_idx];
    assign payload = payload_q[rd_idx];

    // Superpage keeps 22 offset bits from the vaddr
    assign paddr = super_q[rd_idx] ? {rd_ppn[21:10], vaddr[21:0]}
                                   : {rd_ppn, vaddr[11:0]};

    // Refill slot follows the same split as lookup
    assign wr_idx = upd_super ? upd_vpn[10 +: IDX_W] : upd_vpn[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;   // Wins over a same-cycle refill
        end else if (upd) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry contents, written on refill
    always_ff @(posedge clk) begin
        if (upd) begin
            super_q[wr_idx]   <= upd_super;
            vpn1_q[wr_idx]    <= upd_vpn[19:10];
            vpn0_q[wr_idx]    <= upd_vpn[9:0];
            ppn_q[wr_idx]     <= upd_ppn;
            payload_q[wr_idx] <= upd_payload;
        end
    end

    // Nothing survives a flush, refill in the same cycle included
    a_flush_wins: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> (valid_q == '0)
    );

    // Hits need a request and cannot follow a flush directly
    a_hit_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        hit |-> req && !$past(flush)
    );

endmodule

`default_nettype wire

// File: logic/page_walker.sv
`default_nettype none

module page_walker (
    input  logic                  clk,
    input  logic                  rst_n,

    // Misses from both TLBs
    input  logic                  i_miss,
    input  wire sv32_pkg::vaddr_t i_vaddr,
    input  logic                  d_miss,
    input  wire sv32_pkg::vaddr_t d_vaddr,
    input  logic                  flush,
    input  wire sv32_pkg::ppn_t   satp_ppn,

    // Page-table memory port
    output logic                  mem_req,
    output sv32_pkg::paddr_t      mem_addr,
    input  logic                  mem_valid,
    input  logic [31:0]           mem_rdata,

    // Refill toward the TLBs
    output logic                  i_upd,
    output logic                  d_upd,
    output sv32_pkg::vpn_t        upd_vpn,
    output sv32_pkg::ppn_t        upd_ppn,
    output logic                  upd_super,
    output sv32_pkg::pte_t        upd_pte,
    output logic                  i_fault,
    output logic                  d_fault
);
    import sv32_pkg::*;
    import walk_pkg::*;

    walk_state_t state_q;
    miss_src_t   src_q;
    logic        abort_q;   // Flushed while a read is out
    vpn_t        vpn_q;
    pte_t        pte_q;
    logic        super_q;
    paddr_t      addr_q;

    pte_t        pte;
    logic        pte_bad;
    logic        pte_leaf;
    logic        i_take;
    logic        d_take;
    vpn_t        miss_vpn;

    assign pte      = pte_t'(mem_rdata);
    assign pte_bad  = !pte.v || (pte.w && !pte.r);   // Invalid or reserved
    assign pte_leaf = pte.r || pte.x;

    // The side whose fault is on the wire is not taken again
    assign i_take   = i_miss && !i_fault;
    assign d_take   = d_miss && !d_fault;
    assign miss_vpn = i_take ? i_vaddr[31:12] : d_vaddr[31:12];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            src_q   <= INSTR;
            abort_q <= 1'b0;
            i_fault <= 1'b0;
            d_fault <= 1'b0;
        end else begin
            i_fault <= 1'b0;
            d_fault <= 1'b0;
            case (state_q)
                IDLE: begin
                    abort_q <= 1'b0;
                    if (i_take || d_take) begin
                        src_q   <= i_take ? INSTR : DATA;   // Instruction first
                        state_q <= L1_READ;
                    end
                end
                L1_READ, L0_READ: begin
                    if (mem_valid) begin
                        if (abort_q || flush) begin
                            state_q <= IDLE;   // Drop the stale answer
                        end else if (pte_bad || (state_q == L0_READ && !pte_leaf)) begin
                            i_fault <= (src_q == INSTR);
                            d_fault <= (src_q == DATA);
                            state_q <= IDLE;
                        end else if (pte_leaf) begin
                            state_q <= REFILL;
                        end else begin
                            state_q <= L0_READ;   // Pointer to the next level
                        end
                    end else if (flush) begin
                        abort_q <= 1'b1;   // Request stays up until memory answers
                    end
                end
                REFILL: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Walk data path
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            vpn_q  <= miss_vpn;
            addr_q <= {satp_ppn, miss_vpn[19:10], 2'b00};
        end else if (mem_valid) begin
            pte_q   <= pte;
            super_q <= (state_q == L1_READ);   // Leaf at root is 4 MB
            addr_q  <= {pte.ppn1, pte.ppn0, vpn_q[9:0], 2'b00};
        end
    end

    assign mem_req  = (state_q == L1_READ) || (state_q == L0_READ);
    assign mem_addr = addr_q;

    assign i_upd     = (state_q == REFILL) && (src_q == INSTR);
    assign d_upd     = (state_q == REFILL) && (src_q == DATA);
    assign upd_vpn   = vpn_q;
    assign upd_ppn   = {pte_q.ppn1, pte_q.ppn0};
    assign upd_super = super_q;
    assign upd_pte   = pte_q;

    // Memory sees one held address per read
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req && !mem_valid |=> mem_req && $stable(mem_addr)
    );

    // One TLB refilled at a time, always right after a response
    a_upd_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_upd || d_upd) |-> !(i_upd && d_upd) && $past(mem_valid)
    );

    a_upd_no_fault: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((i_upd || d_upd) && (i_fault || d_fault))
    );

endmodule

`default_nettype wire

// File: logic/mmu_top.sv
`default_nettype none

`include "mmu_settings.svh"

module mmu_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Instruction side
    input  logic                  i_req,
    input  wire sv32_pkg::vaddr_t i_vaddr,
    output logic                  i_hit,
    output sv32_pkg::paddr_t      i_paddr,
    output sv32_pkg::itlb_perm_t  i_perm,
    output logic                  i_fault,

    // Data side
    input  logic                  d_req,
    input  wire sv32_pkg::vaddr_t d_vaddr,
    output logic                  d_hit,
    output sv32_pkg::paddr_t      d_paddr,
    output sv32_pkg::dtlb_perm_t  d_perm,
    output logic                  d_fault,

    input  logic                  flush,
    input  wire sv32_pkg::ppn_t   satp_ppn,   // Root table page

    // Page-table memory
    output logic                  mem_req,
    output sv32_pkg::paddr_t      mem_addr,
    input  logic                  mem_valid,
    input  logic [31:0]           mem_rdata
);
    import sv32_pkg::*;

    logic i_miss;
    logic d_miss;
    logic i_upd;
    logic d_upd;
    vpn_t upd_vpn;
    ppn_t upd_ppn;
    logic upd_super;
    pte_t upd_pte;

    tlb #(
        .payload_t (itlb_perm_t),
        .ENTRIES   (`MMU_ITLB_ENTRIES)
    ) u_itlb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (i_req),
        .vaddr       (i_vaddr),
        .hit         (i_hit),
        .miss        (i_miss),
        .paddr       (i_paddr),
        .payload     (i_perm),
        .flush       (flush),
        .upd         (i_upd),
        .upd_vpn     (upd_vpn),
        .upd_ppn     (upd_ppn),
        .upd_super   (upd_super),
        .upd_payload (itlb_perm_t'{x: upd_pte.x, u: upd_pte.u})
    );

    tlb #(
        .payload_t (dtlb_perm_t),
        .ENTRIES   (`MMU_DTLB_ENTRIES)
    ) u_dtlb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (d_req),
        .vaddr       (d_vaddr),
        .hit         (d_hit),
        .miss        (d_miss),
        .paddr       (d_paddr),
        .payload     (d_perm),
        .flush       (flush),
        .upd         (d_upd),
        .upd_vpn     (upd_vpn),
        .upd_ppn     (upd_ppn),
        .upd_super   (upd_super),
        .upd_payload (dtlb_perm_t'{r: upd_pte.r, w: upd_pte.w, u: upd_pte.u})
    );

    // Shared walker, one walk at a time
    page_walker u_walker (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_miss    (i_miss),
        .i_vaddr   (i_vaddr),
        .d_miss    (d_miss),
        .d_vaddr   (d_vaddr),
        .flush     (flush),
        .satp_ppn  (satp_ppn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .i_upd     (i_upd),
        .d_upd     (d_upd),
        .upd_vpn   (upd_vpn),
        .upd_ppn   (upd_ppn),
        .upd_super (upd_super),
        .upd_pte   (upd_pte),
        .i_fault   (i_fault),
        .d_fault   (d_fault)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mmu_top.sv
`default_nettype none

module tb_mmu_top;
    import sv32_pkg::*;

    localparam int     DRIVE_DLY    = 10;
    localparam int     RESET_CYCLES = 4;
    localparam int     REQ_COUNT    = 10;
    localparam int     CYCLE_LIMIT  = REQ_COUNT * 16 + RESET_CYCLES;
    localparam ppn_t   ROOT_PPN     = 22'h00100;
    localparam vaddr_t VA_I4K       = 32'h0040_3abc;   // vpn1 1, vpn0 3
    localparam vaddr_t VA_I2        = 32'h0041_5000;
    localparam vaddr_t VA_IBAD      = 32'h0080_2000;   // Empty root slot
    localparam vaddr_t VA_DSP       = 32'h0c80_1234;   // 4 MB page, vpn1 0x32
    localparam vaddr_t VA_DSP2      = 32'h0cbf_fff0;   // Same superpage
    localparam vaddr_t VA_D2        = 32'h0040_7010;
    localparam vaddr_t VA_DRSV      = 32'h00c0_1000;   // W without R

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i_req;
    logic       d_req;
    logic       flush;
    vaddr_t     i_vaddr;
    vaddr_t     d_vaddr;
    ppn_t       satp_ppn;
    logic       i_hit;
    logic       d_hit;
    logic       i_fault;
    logic       d_fault;
    paddr_t     i_paddr;
    paddr_t     d_paddr;
    itlb_perm_t i_perm;
    dtlb_perm_t d_perm;
    logic       mem_req;
    logic       mem_valid;
    paddr_t     mem_addr;
    logic [31:0] mem_rdata;

    logic [31:0] pt_mem [paddr_t];   // Page tables, missing words read as 0
    logic        mem_busy = 1'b0;
    int          mem_wait;
    int          reads_since_req = 0;
    int          errors = 0;
    int          req_total = 0;
    int          cycle_count = 0;
    logic        req_seen = 1'b0;
    paddr_t      exp_i_paddr = '0;
    paddr_t      exp_d_paddr = '0;
    itlb_perm_t  exp_i_perm = '0;
    dtlb_perm_t  exp_d_perm = '0;
    logic        exp_i_fault = 1'b0;
    logic        exp_d_fault = 1'b0;
    int          exp_i_reads = 0;
    int          exp_d_reads = 0;
    paddr_t      exp_addr [4] = '{default: '0};   // Walk reads in issue order
    paddr_t      exp_mem_addr;

    mmu_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .i_req(i_req), .i_vaddr(i_vaddr), .i_hit(i_hit), .i_paddr(i_paddr),
        .i_perm(i_perm), .i_fault(i_fault),
        .d_req(d_req), .d_vaddr(d_vaddr), .d_hit(d_hit), .d_paddr(d_paddr),
        .d_perm(d_perm), .d_fault(d_fault),
        .flush(flush), .satp_ppn(satp_ppn),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_valid(mem_valid), .mem_rdata(mem_rdata)
    );

    always #50 clk = ~clk;

    assign exp_mem_addr = exp_addr[reads_since_req[1:0]];

    function automatic logic [31:0] read_word(input paddr_t addr);
        if (pt_mem.exists(addr)) begin
            return pt_mem[addr];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // Reference Sv32 walk over the same table
    function automatic void walk_table(input vaddr_t va, output paddr_t pa,
                                       output logic [7:0] flags, output logic fault,
                                       output int reads, output paddr_t l1_addr,
                                       output paddr_t l0_addr);
        paddr_t      addr;
        logic [31:0] entry;
        int          level;
        pa      = '0;
        flags   = '0;
        fault   = 1'b0;
        reads   = 0;
        addr    = {ROOT_PPN, va[31:22], 2'b00};
        l1_addr = addr;
        l0_addr = '0;
        for (level = 1; level >= 0; level--) begin
            entry = read_word(addr);
            reads++;
            if (!entry[0] || (entry[2] && !entry[1])) begin
                fault = 1'b1;
                return;
            end
            if (entry[1] || entry[3]) begin   // Leaf
                flags = entry[7:0];
                pa = (level == 1) ? {entry[31:20], va[21:0]} : {entry[31:10], va[11:0]};
                return;
            end
            if (level == 0) begin
                fault = 1'b1;   // Pointer at the last level
                return;
            end
            addr    = {entry[31:10], va[21:12], 2'b00};
            l0_addr = addr;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("FAIL %s expected %h got %h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Raise one or both requests, hold them until hit or fault
    // A cached translation hits without any memory read
    task automatic run_requests(input logic use_i, input vaddr_t va_i,
                                input logic use_d, input vaddr_t va_d,
                                input logic cached);
        paddr_t     pa;
        logic [7:0] flags;
        logic       fault;
        int         reads;
        paddr_t     l1_addr;
        paddr_t     l0_addr;
        int         i_reads;
        logic       i_done;
        logic       d_done;
        i_reads = 0;
        if (use_i) begin
            walk_table(va_i, pa, flags, fault, reads, l1_addr, l0_addr);
            exp_i_paddr = pa;
            exp_i_perm  = itlb_perm_t'{x: flags[3], u: flags[4]};
            exp_i_fault = fault;
            exp_i_reads = cached ? 0 : reads;
            i_reads     = exp_i_reads;
            exp_addr[0] = l1_addr;
            exp_addr[1] = l0_addr;
            i_vaddr     = va_i;
            i_req       = 1'b1;
        end
        if (use_d) begin
            walk_table(va_d, pa, flags, fault, reads, l1_addr, l0_addr);
            exp_d_paddr = pa;
            exp_d_perm  = dtlb_perm_t'{r: flags[1], w: flags[2], u: flags[4]};
            exp_d_fault = fault;
            // Data walk waits behind the instruction walk
            exp_d_reads = i_reads + (cached ? 0 : reads);
            exp_addr[i_reads]     = l1_addr;
            exp_addr[i_reads + 1] = l0_addr;
            d_vaddr     = va_d;
            d_req       = 1'b1;
        end
        req_total += int'(use_i) + int'(use_d);
        reads_since_req = 0;
        req_seen = 1'b1;
        i_done = !use_i;
        d_done = !use_d;
        while (i_req || d_req) begin
            step_cycle();
            if (i_done) i_req = 1'b0;
            if (d_done) d_req = 1'b0;
            if (i_req && (i_hit || i_fault)) i_done = 1'b1;
            if (d_req && (d_hit || d_fault)) d_done = 1'b1;
        end
        step_cycle();
    endtask

    // Page-table memory, answers after 1 to 4 cycles
    always @(posedge clk) begin
        #DRIVE_DLY;
        mem_valid = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid = 1'b1;
                mem_rdata = read_word(mem_addr);
                mem_busy  = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else if (rst_n && mem_req) begin
            mem_busy = 1'b1;
            mem_wait = $urandom_range(3, 0);
        end
    end

    always @(posedge clk) begin
        if (mem_valid) reads_since_req <= reads_since_req + 1;
    end

    a_i_paddr: assert property (@(posedge clk) disable iff (!rst_n)
        i_hit |-> i_paddr == exp_i_paddr)
        else report_mismatch("i_paddr", $sampled(exp_i_paddr), $sampled(i_paddr));
    a_i_perm: assert property (@(posedge clk) disable iff (!rst_n)
        i_hit |-> i_perm == exp_i_perm)
        else report_mismatch("i_perm", $sampled(exp_i_perm), $sampled(i_perm));
    a_d_paddr: assert property (@(posedge clk) disable iff (!rst_n)
        d_hit |-> d_paddr == exp_d_paddr)
        else report_mismatch("d_paddr", $sampled(exp_d_paddr), $sampled(d_paddr));
    a_d_perm: assert property (@(posedge clk) disable iff (!rst_n)
        d_hit |-> d_perm == exp_d_perm)
        else report_mismatch("d_perm", $sampled(exp_d_perm), $sampled(d_perm));

    // Memory reads seen when the hit first rises
    a_i_reads: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_hit) |-> reads_since_req == exp_i_reads)
        else report_mismatch("i_reads", $sampled(exp_i_reads), $sampled(reads_since_req));
    a_d_reads: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(d_hit) |-> reads_since_req == exp_d_reads)
        else report_mismatch("d_reads", $sampled(exp_d_reads), $sampled(reads_since_req));

    // Each read goes where the Sv32 walk expects it next
    a_mem_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |-> mem_addr == exp_mem_addr)
        else report_mismatch("mem_addr", $sampled(exp_mem_addr), $sampled(mem_addr));

    a_i_fault: assert property (@(posedge clk) disable iff (!rst_n) i_fault |-> exp_i_fault)
        else report_failure("instruction fault without a bad page-table entry");
    a_d_fault: assert property (@(posedge clk) disable iff (!rst_n) d_fault |-> exp_d_fault)
        else report_failure("data fault without a bad page-table entry");
    a_i_no_hit: assert property (@(posedge clk) disable iff (!rst_n) i_hit |-> !exp_i_fault)
        else report_failure("instruction hit on a faulting address");
    a_d_no_hit: assert property (@(posedge clk) disable iff (!rst_n) d_hit |-> !exp_d_fault)
        else report_failure("data hit on a faulting address");

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !req_seen |-> !(mem_req || i_dut.i_upd || i_dut.d_upd || i_fault || d_fault))
        else report_failure("strobe or memory request active before any request");

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure("run exceeded the cycle limit");
        $display("Requests: %0d, errors: %0d", req_total, errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hadae89b7));
        rst_n     = 1'b0;
        i_req     = 1'b0;
        d_req     = 1'b0;
        i_vaddr   = '0;
        d_vaddr   = '0;
        flush     = 1'b0;
        satp_ppn  = ROOT_PPN;
        mem_valid = 1'b0;
        mem_rdata = '0;

        pt_mem[{ROOT_PPN, 10'd1, 2'b00}]    = make_pte(22'h00101, 8'h01);   // Next level
        pt_mem[{22'h00101, 10'd3, 2'b00}]   = make_pte(22'h12345, 8'h5b);
        pt_mem[{22'h00101, 10'h15, 2'b00}]  = make_pte(22'h2a0b1, 8'h59);
        pt_mem[{22'h00101, 10'd7, 2'b00}]   = make_pte(22'h33c01, 8'hc7);
        pt_mem[{ROOT_PPN, 10'h32, 2'b00}]   = make_pte({12'h0ab, 10'h0}, 8'hd7);
        pt_mem[{ROOT_PPN, 10'd3, 2'b00}]    = make_pte(22'h00102, 8'h05);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        repeat (2) step_cycle();   // Idle window after reset

        run_requests(1'b1, VA_I4K, 1'b0, '0, 1'b0);
        run_requests(1'b0, '0, 1'b1, VA_DSP, 1'b0);
        run_requests(1'b0, '0, 1'b1, VA_DSP2, 1'b1);   // Same 4 MB page, no walk
        run_requests(1'b1, VA_IBAD, 1'b0, '0, 1'b0);
        run_requests(1'b0, '0, 1'b1, VA_DRSV, 1'b0);
        run_requests(1'b1, VA_I2, 1'b1, VA_D2, 1'b0);
        run_requests(1'b1, VA_I4K, 1'b0, '0, 1'b1);   // Still cached

        flush = 1'b1;
        step_cycle();
        flush = 1'b0;
        step_cycle();
        run_requests(1'b1, VA_I4K, 1'b0, '0, 1'b0);
        run_requests(1'b0, '0, 1'b1, VA_DSP, 1'b0);

        $display("Requests: %0d, errors: %0d", req_total, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/sv32_pkg.sv
logic/walk_pkg.sv
logic/tlb.sv
logic/page_walker.sv
logic/mmu_top.sv
testbench/tb_mmu_top.sv

// File: Bender.yml
package:
  name: mmu_sv32

sources:
  - include_dirs:
      - logic
    files:
      - logic/sv32_pkg.sv
      - logic/walk_pkg.sv
      - logic/tlb.sv
      - logic/page_walker.sv
      - logic/mmu_top.sv
  - target: test
    files:
      - testbench/tb_mmu_top.sv
